/* common/axil_ram_pkg.sv */
package axil_ram_pkg;

    // Fixed bus geometry
    localparam int axil_addr_width = 32;
    localparam int axil_data_width = 32;
    localparam int axil_strb_width = axil_data_width / 8;

    typedef logic [axil_addr_width-1:0] axil_addr_t;
    typedef logic [axil_data_width-1:0] axil_data_t;
    typedef logic [axil_strb_width-1:0] axil_strb_t;
    typedef logic [2:0]                 axil_prot_t;
    typedef logic [1:0]                 axil_resp_t;

    // AXI response codes
    localparam axil_resp_t resp_okay   = 2'b00;
    localparam axil_resp_t resp_decerr = 2'b11;

    // Write address beat
    typedef struct packed {
        axil_addr_t addr;
        axil_prot_t prot;
    } axil_aw_t;

    // Write data beat
    typedef struct packed {
        axil_data_t data;
        axil_strb_t strb;
    } axil_w_t;

    // Write response
    typedef struct packed {
        axil_resp_t resp;
    } axil_b_t;

    // Read address beat
    typedef struct packed {
        axil_addr_t addr;
        axil_prot_t prot;
    } axil_ar_t;

    // Read response
    typedef struct packed {
        axil_data_t data;
        axil_resp_t resp;
    } axil_r_t;

    // Word aligned and inside the RAM
    function automatic logic addr_ok(
        input axil_addr_t  addr,
        input int unsigned size
    );
        logic aligned;
        logic in_range;
        aligned  = (addr[1:0] == 2'b00);
        in_range = (addr < size);
        return aligned && in_range;
    endfunction

endpackage

/* axil_ram/ram_bank.sv */
`timescale 1ns/10ps

module ram_bank #(
    parameter int unsigned SIZE = 4096,
    localparam int word_bits = (SIZE > 4) ? $clog2(SIZE / 4) : 1
) (
    input  logic                                     seq,

    input  logic                                     wr_en,
    input  logic [word_bits-1:0]                     wr_addr,
    input  logic [axil_ram_pkg::axil_data_width-1:0] wr_data,
    input  logic [axil_ram_pkg::axil_strb_width-1:0] wr_strb,

    input  logic                                     rd_en,
    input  logic [word_bits-1:0]                     rd_addr,
    output logic [axil_ram_pkg::axil_data_width-1:0] rd_data
);
    import axil_ram_pkg::*;

    localparam int words = SIZE / 4;

    axil_data_t mem [words];

    // Byte lanes update independently
    always_ff @(posedge seq) begin
        if (wr_en) begin
            for (int i = 0; i < axil_strb_width; i++) begin
                if (wr_strb[i]) begin
                    mem[wr_addr][8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
        end
    end

    // Read first on a same-word collision
    always_ff @(posedge seq) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* axil_ram/axil_ram_write.sv */
`timescale 1ns/10ps

module axil_ram_write #(
    parameter int unsigned SIZE = 4096,
    localparam int word_bits = (SIZE > 4) ? $clog2(SIZE / 4) : 1
) (
    input  logic                                 seq,
    input  logic                                 arst_n,
    input  logic                                 block,

    input  logic                                 aw_valid,
    output logic                                 aw_ready,
    input  axil_ram_pkg::axil_aw_t               aw,

    input  logic                                 w_valid,
    output logic                                 w_ready,
    input  axil_ram_pkg::axil_w_t                w,

    output logic                                 b_valid,
    input  logic                                 b_ready,
    output axil_ram_pkg::axil_b_t                b,

    output logic                                 write_busy,

    output logic                                 wr_en,
    output logic [word_bits-1:0]                 wr_addr,
    output logic [axil_ram_pkg::axil_data_width-1:0] wr_data,
    output logic [axil_ram_pkg::axil_strb_width-1:0] wr_strb
);
    import axil_ram_pkg::*;

    logic     aw_held;
    logic     w_held;
    axil_aw_t aw_q;
    axil_w_t  w_q;

    axil_aw_t aw_cur;
    axil_w_t  w_cur;
    logic     aw_take;
    logic     w_take;
    logic     commit;
    logic     cur_ok;

    assign aw_ready = !aw_held && !b_valid && !block;
    assign w_ready  = !w_held && !b_valid && !block;

    assign aw_take = aw_valid && aw_ready;
    assign w_take  = w_valid && w_ready;

    // A beat arriving this cycle counts as held
    assign aw_cur = aw_held ? aw_q : aw;
    assign w_cur  = w_held ? w_q : w;
    assign commit = (aw_held || aw_take) && (w_held || w_take);
    assign cur_ok = addr_ok(aw_cur.addr, SIZE);

    assign wr_en   = commit && cur_ok;
    assign wr_addr = aw_cur.addr[word_bits+1:2];
    assign wr_data = w_cur.data;
    assign wr_strb = w_cur.strb;

    assign write_busy = aw_held || w_held || b_valid;

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            b_valid <= 1'b0;
        end else if (commit) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            b_valid <= 1'b1;
        end else begin
            if (aw_take) aw_held <= 1'b1;
            if (w_take) w_held <= 1'b1;
            if (b_valid && b_ready) b_valid <= 1'b0;
        end
    end

    always_ff @(posedge seq) begin
        if (aw_take) aw_q <= aw;
        if (w_take) w_q <= w;
        if (commit) b.resp <= cur_ok ? resp_okay : resp_decerr;
    end

    a_b_stable: assert property (@(posedge seq) disable iff (!arst_n)
        b_valid && !b_ready |=> b_valid && $stable(b));

    // Bank writes only for good addresses, and those answer OKAY
    a_write_ok: assert property (@(posedge seq) disable iff (!arst_n)
        wr_en |-> addr_ok(aw_cur.addr, SIZE) ##1 (b_valid && b.resp == resp_okay));

endmodule

/* axil_ram/axil_ram_read.sv */
`timescale 1ns/10ps

module axil_ram_read #(
    parameter int unsigned SIZE = 4096,
    localparam int word_bits = (SIZE > 4) ? $clog2(SIZE / 4) : 1
) (
    input  logic                                 seq,
    input  logic                                 arst_n,
    input  logic                                 block,

    input  logic                                 ar_valid,
    output logic                                 ar_ready,
    input  axil_ram_pkg::axil_ar_t               ar,

    output logic                                 r_valid,
    input  logic                                 r_ready,
    output axil_ram_pkg::axil_r_t                r,

    output logic                                 read_busy,

    output logic                                 rd_en,
    output logic [word_bits-1:0]                 rd_addr,
    input  logic [axil_ram_pkg::axil_data_width-1:0] rd_data
);
    import axil_ram_pkg::*;

    logic ar_take;
    logic ar_ok;
    logic ok_q;

    // One read in flight at a time
    assign ar_ready = !r_valid && !block;
    assign ar_take  = ar_valid && ar_ready;
    assign ar_ok    = addr_ok(ar.addr, SIZE);

    assign rd_en   = ar_take && ar_ok;
    assign rd_addr = ar.addr[word_bits+1:2];

    assign read_busy = r_valid;

    // Bank output holds until the next read, so r stays put under back-pressure
    assign r.data = ok_q ? rd_data : '0;
    assign r.resp = ok_q ? resp_okay : resp_decerr;

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            r_valid <= 1'b0;
        end else if (ar_take) begin
            r_valid <= 1'b1;
        end else if (r_valid && r_ready) begin
            r_valid <= 1'b0;
        end
    end

    always_ff @(posedge seq) begin
        if (ar_take) begin
            ok_q <= ar_ok;
        end
    end

    a_r_stable: assert property (@(posedge seq) disable iff (!arst_n)
        r_valid && !r_ready |=> r_valid && $stable(r));

endmodule

/* axil_ram/axil_ram_pause.sv */
`timescale 1ns/10ps

module axil_ram_pause (
    input  logic seq,
    input  logic arst_n,

    input  logic pause_req,
    input  logic write_busy,
    input  logic read_busy,

    output logic block,
    output logic pause_ack
);

    logic run;

    // Readies stay low until the first edge after reset release
    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    assign block = pause_req || !run;

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            pause_ack <= 1'b0;
        end else begin
            pause_ack <= pause_req && !write_busy && !read_busy;
        end
    end

    a_ack_idle: assert property (@(posedge seq) disable iff (!arst_n)
        $rose(pause_ack) |-> $past(!write_busy && !read_busy && pause_req));

endmodule

/* axil_ram/axil_ram.sv */
`timescale 1ns/10ps

module axil_ram #(
    parameter int unsigned SIZE = 4096
) (
    input  logic                   seq,
    input  logic                   arst_n,

    input  logic                   pause_req,
    output logic                   pause_ack,

    input  logic                   aw_valid,
    output logic                   aw_ready,
    input  axil_ram_pkg::axil_aw_t aw,

    input  logic                   w_valid,
    output logic                   w_ready,
    input  axil_ram_pkg::axil_w_t  w,

    output logic                   b_valid,
    input  logic                   b_ready,
    output axil_ram_pkg::axil_b_t  b,

    input  logic                   ar_valid,
    output logic                   ar_ready,
    input  axil_ram_pkg::axil_ar_t ar,

    output logic                   r_valid,
    input  logic                   r_ready,
    output axil_ram_pkg::axil_r_t  r
);
    import axil_ram_pkg::*;

    localparam int word_bits = (SIZE > 4) ? $clog2(SIZE / 4) : 1;

    logic                 block;
    logic                 write_busy;
    logic                 read_busy;

    logic                 wr_en;
    logic [word_bits-1:0] wr_addr;
    axil_data_t           wr_data;
    axil_strb_t           wr_strb;

    logic                 rd_en;
    logic [word_bits-1:0] rd_addr;
    axil_data_t           rd_data;

    axil_ram_write #(.SIZE(SIZE)) i_write (
        .seq, .arst_n, .block,
        .aw_valid, .aw_ready, .aw,
        .w_valid, .w_ready, .w,
        .b_valid, .b_ready, .b,
        .write_busy,
        .wr_en, .wr_addr, .wr_data, .wr_strb
    );

    axil_ram_read #(.SIZE(SIZE)) i_read (
        .seq, .arst_n, .block,
        .ar_valid, .ar_ready, .ar,
        .r_valid, .r_ready, .r,
        .read_busy,
        .rd_en, .rd_addr, .rd_data
    );

    ram_bank #(.SIZE(SIZE)) i_bank (
        .seq,
        .wr_en, .wr_addr, .wr_data, .wr_strb,
        .rd_en, .rd_addr, .rd_data
    );

    axil_ram_pause i_pause (
        .seq, .arst_n,
        .pause_req, .write_busy, .read_busy,
        .block, .pause_ack
    );

endmodule

/* verification/axil_ram_tb.sv */
`timescale 1ns/10ps

module axil_ram_tb;
    import axil_ram_pkg::*;

    localparam int unsigned mem_size = 4096;
    localparam int words = mem_size / 4;
    localparam int word_bits = $clog2(words);
    localparam int table_len = 20;
    localparam int random_steps = 40;
    localparam int cycle_limit = (table_len + random_steps) * 20 + 200;
    localparam bit op_wr = 1'b0;
    localparam bit op_rd = 1'b1;

    typedef struct packed {
        logic        is_read;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [7:0]  delay;
        logic [1:0]  resp;
        logic [31:0] exp_data;
    } step_t;

    logic     seq;
    logic     arst_n;
    logic     pause_req;
    logic     pause_ack;
    logic     aw_valid;
    logic     aw_ready;
    axil_aw_t aw;
    logic     w_valid;
    logic     w_ready;
    axil_w_t  w;
    logic     b_valid;
    logic     b_ready;
    axil_b_t  b;
    logic     ar_valid;
    logic     ar_ready;
    axil_ar_t ar;
    logic     r_valid;
    logic     r_ready;
    axil_r_t  r;

    step_t       steps [table_len];
    logic [31:0] model [words];
    logic [3:0]  known [words];
    logic [31:0] rng;
    int          errors;
    int          checks;
    int          cycles;

    axil_ram #(.SIZE(mem_size)) i_axil_ram (
        .seq, .arst_n,
        .pause_req, .pause_ack,
        .aw_valid, .aw_ready, .aw,
        .w_valid, .w_ready, .w,
        .b_valid, .b_ready, .b,
        .ar_valid, .ar_ready, .ar,
        .r_valid, .r_ready, .r
    );

    initial begin
        seq = 1'b0;
        forever #20 seq = ~seq;
    end

    initial begin
        cycles = 0;
        while (cycles <= cycle_limit) begin
            @(posedge seq);
            cycles++;
        end
        $display("Timeout: the run hung and did not finish within %0d cycles", cycle_limit);
        $display("Checks failed");
        $finish;
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    // Aligned to a word and below the RAM size
    function automatic logic addr_in_ram(input logic [31:0] addr);
        return (addr[1:0] == 2'b00) && (addr < mem_size);
    endfunction

    function automatic logic [31:0] byte_mask(input logic [3:0] lanes);
        return {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
    endfunction

    task automatic check_hex(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error: %s expected %h, got %h", name, expected, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("Failure: %s", msg);
    endtask

    task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
            input logic [3:0] strb);
        logic [word_bits-1:0] idx;
        idx = addr[word_bits+1:2];
        if (addr_in_ram(addr)) begin
            for (int k = 0; k < 4; k++) begin
                if (strb[k]) begin
                    model[idx][8*k +: 8] = data[8*k +: 8];
                end
            end
            known[idx] = known[idx] | strb;
        end
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
            input logic [3:0] strb, input logic [7:0] delay, output logic [1:0] resp);
        logic    aw_hs;
        logic    w_hs;
        logic    aw_done;
        logic    w_done;
        axil_b_t held;
        aw_done = 1'b0;
        w_done = 1'b0;
        @(negedge seq);
        aw_valid = 1'b1;
        aw.addr = addr;
        aw.prot = 3'b000;
        w_valid = 1'b1;
        w.data = data;
        w.strb = strb;
        while (!(aw_done && w_done)) begin
            // Readies only change on the rising edge
            aw_hs = aw_valid && aw_ready;
            w_hs = w_valid && w_ready;
            @(negedge seq);
            if (aw_hs) begin
                aw_valid = 1'b0;
                aw_done = 1'b1;
            end
            if (w_hs) begin
                w_valid = 1'b0;
                w_done = 1'b1;
            end
        end
        if (!b_valid) begin
            report_failure("b_valid did not rise one cycle after the last write handshake");
        end
        while (!b_valid) begin
            @(negedge seq);
        end
        held = b;
        repeat (delay) begin
            @(negedge seq);
            if (!b_valid) begin
                report_failure("b_valid dropped while b_ready was low");
            end
            check_hex("b.resp", 32'(held.resp), 32'(b.resp));
            check_hex("aw_ready", 32'(1'b0), 32'(aw_ready));
        end
        resp = b.resp;
        b_ready = 1'b1;
        @(negedge seq);
        b_ready = 1'b0;
    endtask

    task automatic read_word(input logic [31:0] addr, input logic [7:0] delay,
            output logic [1:0] resp, output logic [31:0] data);
        logic    ar_hs;
        axil_r_t held;
        ar_hs = 1'b0;
        @(negedge seq);
        ar_valid = 1'b1;
        ar.addr = addr;
        ar.prot = 3'b000;
        while (!ar_hs) begin
            ar_hs = ar_ready;
            @(negedge seq);
        end
        ar_valid = 1'b0;
        if (!r_valid) begin
            report_failure("r_valid did not rise one cycle after the AR handshake");
        end
        while (!r_valid) begin
            @(negedge seq);
        end
        held = r;
        repeat (delay) begin
            @(negedge seq);
            if (!r_valid) begin
                report_failure("r_valid dropped while r_ready was low");
            end
            check_hex("r.data", held.data, r.data);
            check_hex("r.resp", 32'(held.resp), 32'(r.resp));
            check_hex("ar_ready", 32'(1'b0), 32'(ar_ready));
        end
        resp = r.resp;
        data = r.data;
        r_ready = 1'b1;
        @(negedge seq);
        r_ready = 1'b0;
    endtask

    task automatic load_table();
        steps[0]  = '{op_wr, 32'h0000_0000, 32'h1122_3344, 4'hf, 8'd0, resp_okay,   32'h0};
        steps[1]  = '{op_wr, 32'h0000_0004, 32'ha5a5_0f0f, 4'hf, 8'd2, resp_okay,   32'h0};
        steps[2]  = '{op_wr, 32'h0000_0ffc, 32'hdead_beef, 4'hf, 8'd0, resp_okay,   32'h0};
        steps[3]  = '{op_rd, 32'h0000_0000, 32'h0,         4'h0, 8'd0, resp_okay,   32'h1122_3344};
        steps[4]  = '{op_rd, 32'h0000_0004, 32'h0,         4'h0, 8'd3, resp_okay,   32'ha5a5_0f0f};
        steps[5]  = '{op_rd, 32'h0000_0ffc, 32'h0,         4'h0, 8'd0, resp_okay,   32'hdead_beef};
        // Partial strobes merge into the old word
        steps[6]  = '{op_wr, 32'h0000_0000, 32'haabb_ccdd, 4'h3, 8'd0, resp_okay,   32'h0};
        steps[7]  = '{op_wr, 32'h0000_0004, 32'h9900_0000, 4'h8, 8'd1, resp_okay,   32'h0};
        steps[8]  = '{op_rd, 32'h0000_0000, 32'h0,         4'h0, 8'd0, resp_okay,   32'h1122_ccdd};
        steps[9]  = '{op_rd, 32'h0000_0004, 32'h0,         4'h0, 8'd0, resp_okay,   32'h99a5_0f0f};
        steps[10] = '{op_wr, 32'h0000_0002, 32'hffff_ffff, 4'hf, 8'd0, resp_decerr, 32'h0};
        steps[11] = '{op_rd, 32'h0000_0002, 32'h0,         4'h0, 8'd2, resp_decerr, 32'h0};
        steps[12] = '{op_rd, 32'h0000_0000, 32'h0,         4'h0, 8'd0, resp_okay,   32'h1122_ccdd};
        steps[13] = '{op_wr, 32'h0000_1000, 32'h1234_5678, 4'hf, 8'd0, resp_decerr, 32'h0};
        steps[14] = '{op_rd, 32'h0000_1000, 32'h0,         4'h0, 8'd0, resp_decerr, 32'h0};
        steps[15] = '{op_rd, 32'h0000_0000, 32'h0,         4'h0, 8'd0, resp_okay,   32'h1122_ccdd};
        steps[16] = '{op_rd, 32'h0000_1ffc, 32'h0,         4'h0, 8'd0, resp_decerr, 32'h0};
        steps[17] = '{op_wr, 32'h0000_0001, 32'h0bad_0bad, 4'hf, 8'd0, resp_decerr, 32'h0};
        steps[18] = '{op_wr, 32'h0000_0100, 32'h0bad_f00d, 4'hf, 8'd4, resp_okay,   32'h0};
        steps[19] = '{op_rd, 32'h0000_0100, 32'h0,         4'h0, 8'd4, resp_okay,   32'h0bad_f00d};
    endtask

    task automatic run_table();
        logic [1:0]  resp;
        logic [31:0] data;
        for (int i = 0; i < table_len; i++) begin
            if (steps[i].is_read) begin
                read_word(steps[i].addr, steps[i].delay, resp, data);
                check_hex("r.resp", 32'(steps[i].resp), 32'(resp));
                check_hex("r.data", steps[i].exp_data, data);
            end else begin
                write_word(steps[i].addr, steps[i].data, steps[i].strb, steps[i].delay, resp);
                check_hex("b.resp", 32'(steps[i].resp), 32'(resp));
                model_write(steps[i].addr, steps[i].data, steps[i].strb);
            end
        end
    endtask

    task automatic run_pause();
        logic [1:0]  resp;
        logic [31:0] data;
        @(negedge seq);
        pause_req = 1'b1;
        @(negedge seq);
        while (!pause_ack) begin
            @(negedge seq);
        end
        repeat (3) begin
            check_hex("aw_ready", 32'(1'b0), 32'(aw_ready));
            check_hex("ar_ready", 32'(1'b0), 32'(ar_ready));
            check_hex("pause_ack", 32'(1'b1), 32'(pause_ack));
            @(negedge seq);
        end
        pause_req = 1'b0;
        @(negedge seq);
        check_hex("pause_ack", 32'(1'b0), 32'(pause_ack));
        write_word(32'h0000_0200, 32'h5a5a_c3c3, 4'hf, 8'd0, resp);
        check_hex("b.resp", 32'(resp_okay), 32'(resp));
        model_write(32'h0000_0200, 32'h5a5a_c3c3, 4'hf);
        read_word(32'h0000_0200, 8'd0, resp, data);
        check_hex("r.resp", 32'(resp_okay), 32'(resp));
        check_hex("r.data", 32'h5a5a_c3c3, data);
    endtask

    task automatic run_random();
        logic [31:0]          rnd;
        logic [31:0]          addr;
        logic [31:0]          data;
        logic [3:0]           strb;
        logic [1:0]           resp;
        logic [31:0]          mask;
        logic [word_bits-1:0] idx;
        for (int i = 0; i < random_steps; i++) begin
            rnd = next_random();
            addr = {19'b0, rnd[12:0]};
            if (i % 2 == 0) begin
                addr[1:0] = 2'b00;
            end
            data = next_random();
            strb = rnd[16:13];
            write_word(addr, data, strb, {6'b0, rnd[18:17]}, resp);
            check_hex("b.resp", 32'(addr_in_ram(addr) ? resp_okay : resp_decerr), 32'(resp));
            model_write(addr, data, strb);
            read_word(addr, {6'b0, rnd[20:19]}, resp, data);
            if (addr_in_ram(addr)) begin
                // Bytes never written hold no defined value
                idx = addr[word_bits+1:2];
                mask = byte_mask(known[idx]);
                check_hex("r.resp", 32'(resp_okay), 32'(resp));
                check_hex("r.data", model[idx] & mask, data & mask);
            end else begin
                check_hex("r.resp", 32'(resp_decerr), 32'(resp));
                check_hex("r.data", 32'h0, data);
            end
        end
    endtask

    initial begin
        arst_n = 1'b0;
        pause_req = 1'b0;
        aw_valid = 1'b0;
        aw = '0;
        w_valid = 1'b0;
        w = '0;
        b_ready = 1'b0;
        ar_valid = 1'b0;
        ar = '0;
        r_ready = 1'b0;
        errors = 0;
        checks = 0;
        rng = 32'd27574;
        for (int i = 0; i < words; i++) begin
            model[i] = 32'h0;
            known[i] = 4'h0;
        end
        load_table();
        repeat (2) @(negedge seq);
        check_hex("aw_ready", 32'(1'b0), 32'(aw_ready));
        check_hex("w_ready", 32'(1'b0), 32'(w_ready));
        check_hex("ar_ready", 32'(1'b0), 32'(ar_ready));
        check_hex("b_valid", 32'(1'b0), 32'(b_valid));
        check_hex("r_valid", 32'(1'b0), 32'(r_valid));
        check_hex("pause_ack", 32'(1'b0), 32'(pause_ack));
        @(negedge seq);
        arst_n = 1'b1;
        @(negedge seq);
        check_hex("aw_ready", 32'(1'b1), 32'(aw_ready));
        check_hex("w_ready", 32'(1'b1), 32'(w_ready));
        check_hex("ar_ready", 32'(1'b1), 32'(ar_ready));
        run_table();
        run_pause();
        run_random();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* list.f */
common/axil_ram_pkg.sv
axil_ram/ram_bank.sv
axil_ram/axil_ram_write.sv
axil_ram/axil_ram_read.sv
axil_ram/axil_ram_pause.sv
axil_ram/axil_ram.sv
verification/axil_ram_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= axil_ram_tb
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
PASS_MSG  := All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
